//--- compile.f
hw/rvcDecodePkg.sv
hw/rvcStageIf.sv
hw/rvcCreditCounter.sv
hw/rvcClassifyStage.sv
hw/rvcOperandStage.sv
hw/rvcDecoder.sv
dv/tbClockGen.sv
dv/rvcDecoder_sva.sv
dv/rvcDecoderTb.sv

//--- dv/rvcDecoderTb.sv
// --------------------------------------------------
// directed RVC words then 300 random ones
// field checks live in the bound assertion module
// --------------------------------------------------
`timescale 1ns/1ps

module rvcDecoderTb;

	localparam int directedCount = 47;
	localparam int randomCount = 300;
	localparam int totalItems = directedCount + randomCount;
	localparam logic [15:0] directedWords [0:directedCount-1] = '{
		16'h0000, 16'h0040, 16'h1FFC, 16'h4398, 16'h6F64, 16'hC3A4, 16'hE7C8, 16'h2404,
		16'hA404, 16'h8404, 16'h1105, 16'h0001, 16'h1065, 16'h3FFD, 16'h5285, 16'h7301,
		16'h7101, 16'h8085, 16'h9485, 16'h997D, 16'h8C09, 16'h8C2D, 16'h8C49, 16'h8C6D,
		16'h9C09, 16'h9C2D, 16'h9C4D, 16'hA805, 16'hBFFD, 16'hC001, 16'hDC7D, 16'hE0FD,
		16'h0206, 16'h4522, 16'h7FFA, 16'hC28A, 16'hE6A6, 16'h8522, 16'h8082, 16'h952E,
		16'h9582, 16'h9002, 16'h8002, 16'h2002, 16'hA002, 16'hFFFF, 16'h0013
	};

	logic clock;
	logic reset;
	logic inValid;
	logic [15:0] inInstr;
	logic inReady;
	logic outValid;
	rvcDecodePkg::opClassT outOpClass;
	rvcDecodePkg::aluFuncT outAluFunc;
	rvcDecodePkg::memSizeT outMemSize;
	logic [4:0] outRd;
	logic [4:0] outRs1;
	logic [4:0] outRs2;
	logic [31:0] outImm;
	logic creditReturn;
	logic withhold;
	int stimSeed = 42;
	int creditSeed = 42;
	int pending = 0;
	int delivered = 0;

	tbClockGen clockGen (
		.clock(clock),
		.reset(reset)
	);

	rvcDecoder #(
		.immWidth(32),
		.numCredits(4)
	) UUT (
		.clock(clock),
		.reset(reset),
		.inValid(inValid),
		.inInstr(inInstr),
		.inReady(inReady),
		.outValid(outValid),
		.outOpClass(outOpClass),
		.outAluFunc(outAluFunc),
		.outMemSize(outMemSize),
		.outRd(outRd),
		.outRs1(outRs1),
		.outRs2(outRs2),
		.outImm(outImm),
		.creditReturn(creditReturn)
	);

	// offer a word and hold it until the edge that accepts it
	task automatic sendWord(input logic [15:0] w);
		inValid <= 1'b1;
		inInstr <= w;
		do @(negedge clock); while (!inReady);
		@(posedge clock);
		if (($random(stimSeed) & 7) == 0) begin
			inValid <= 1'b0;
			@(posedge clock);
		end
	endtask

	// credits go back a random while after each delivered item
	always @(posedge clock) begin
		if (reset) begin
			creditReturn <= 1'b0;
		end else begin
			if (outValid) begin
				pending++;
				delivered++;
			end
			if (pending > 0 && !withhold && ($random(creditSeed) & 3) != 0) begin
				creditReturn <= 1'b1;
				pending--;
			end else begin
				creditReturn <= 1'b0;
			end
		end
	end

	initial begin
		inValid = 1'b0;
		inInstr = '0;
		creditReturn = 1'b0;
		withhold = 1'b1;
		@(negedge reset);
		@(posedge clock);
		fork
			begin
				repeat (20) @(posedge clock);
				withhold <= 1'b0;
			end
		join_none
		for (int i = 0; i < directedCount; i++) begin
			sendWord(directedWords[i]);
		end
		for (int i = 0; i < randomCount; i++) begin
			sendWord(16'($random(stimSeed)));
		end
		inValid <= 1'b0;
		wait (delivered == totalItems);
		repeat (5) @(posedge clock);
		if (UUT.checks.failCount == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("Testbench failed");
			$fatal(1);
		end
	end

	initial begin
		wait (UUT.checks.failCount != 0);
		$display("mismatch in %s: expected %h, actual %h", UUT.checks.failName,
			UUT.checks.failExpected, UUT.checks.failActual);
		$display("Testbench failed");
		$fatal(1);
	end

	// four cycles per item plus 1 us of slack
	initial begin
		#(totalItems * 4 * 10 + 1000);
		$display("run timed out before all items were delivered");
		$display("Testbench failed");
		$fatal(1);
	end

endmodule

//--- dv/rvcDecoder_sva.sv
// --------------------------------------------------
// decoder checks bound into rvcDecoder
// expects downstream never to return unearned credits
// --------------------------------------------------
`timescale 1ns/1ps

module rvcDecoderAssertions #(
	parameter int immWidth = 32,
	parameter int numCredits = 4
) (
	input logic clock,
	input logic reset,
	input logic inValid,
	input logic [15:0] inInstr,
	input logic inReady,
	input logic creditReturn,
	input logic outValid,
	input rvcDecodePkg::opClassT outOpClass,
	input rvcDecodePkg::aluFuncT outAluFunc,
	input rvcDecodePkg::memSizeT outMemSize,
	input logic [4:0] outRd,
	input logic [4:0] outRs1,
	input logic [4:0] outRs2,
	input logic [immWidth-1:0] outImm
);

	int failCount = 0;
	string failName;
	logic [63:0] failExpected;
	logic [63:0] failActual;
	logic [15:0] word1;
	logic [15:0] word2;
	logic acc1;
	logic acc2;
	int outstanding;
	rvcDecodePkg::opClassT expClass;
	rvcDecodePkg::aluFuncT expAlu;
	logic [14:0] expRegs;
	logic [63:0] expImm;

	task automatic noteFailure(input string name, input logic [63:0] e, input logic [63:0] a);
		if (failCount == 0) begin
			failName = name;
			failExpected = e;
			failActual = a;
		end
		failCount++;
	endtask

	function automatic rvcDecodePkg::opClassT classOf(input logic [15:0] w);
		logic [2:0] f;
		f = w[15:13];
		case (w[1:0])
			2'b00: begin
				if (w == 16'h0000) return rvcDecodePkg::brk;
				if (f == 3'd0) return rvcDecodePkg::aluImm;
				if (f == 3'd2 || f == 3'd3) return rvcDecodePkg::load;
				if (f == 3'd6 || f == 3'd7) return rvcDecodePkg::store;
				return rvcDecodePkg::invalid;
			end
			2'b01: begin
				if (f == 3'd0 && w[11:7] == 5'd0) return rvcDecodePkg::nop;
				if (f == 3'd5) return rvcDecodePkg::jump;
				if (f == 3'd6) return rvcDecodePkg::branchEq;
				if (f == 3'd7) return rvcDecodePkg::branchNe;
				if (f != 3'd4 || w[11:10] != 2'b11) return rvcDecodePkg::aluImm;
				if ({w[12], w[6:5]} >= 3'd6) return rvcDecodePkg::invalid;
				return rvcDecodePkg::aluReg;
			end
			2'b10: begin
				if (f == 3'd0) return rvcDecodePkg::aluImm;
				if (f == 3'd2 || f == 3'd3) return rvcDecodePkg::load;
				if (f == 3'd6 || f == 3'd7) return rvcDecodePkg::store;
				if (f != 3'd4) return rvcDecodePkg::invalid;
				if (w[6:2] != 5'd0) return rvcDecodePkg::aluReg;
				if (w[11:7] == 5'd0) return rvcDecodePkg::brk;
				return w[12] ? rvcDecodePkg::jumpLink : rvcDecodePkg::jump;
			end
			default: return rvcDecodePkg::nop;
		endcase
	endfunction

	// only meaningful for the aluReg and aluImm classes
	function automatic rvcDecodePkg::aluFuncT aluOf(input logic [15:0] w);
		case ({w[1:0], w[15:13]})
			5'b01001: return rvcDecodePkg::addWord;
			5'b01100: begin
				if (w[11:10] == 2'b00) return rvcDecodePkg::shiftRightLogic;
				if (w[11:10] == 2'b01) return rvcDecodePkg::shiftRightArith;
				if (w[11:10] == 2'b10) return rvcDecodePkg::andOp;
				case ({w[12], w[6:5]})
					3'b000: return rvcDecodePkg::sub;
					3'b001: return rvcDecodePkg::xorOp;
					3'b010: return rvcDecodePkg::orOp;
					3'b011: return rvcDecodePkg::andOp;
					3'b100: return rvcDecodePkg::subWord;
					default: return rvcDecodePkg::addWord;
				endcase
			end
			5'b10000: return rvcDecodePkg::shiftLeft;
			5'b10100: return w[12] ? rvcDecodePkg::add : rvcDecodePkg::move;
			default: return rvcDecodePkg::add;
		endcase
	endfunction

	// {rd, rs1, rs2}
	function automatic logic [14:0] regsOf(input logic [15:0] w);
		logic [4:0] hi;
		logic [4:0] lo;
		logic [4:0] ch;
		logic [4:0] cl;
		logic [2:0] f;
		rvcDecodePkg::opClassT c;
		hi = w[11:7];
		lo = w[6:2];
		ch = 5'd8 + w[9:7];
		cl = 5'd8 + w[4:2];
		f = w[15:13];
		c = classOf(w);
		if (c inside {rvcDecodePkg::nop, rvcDecodePkg::brk, rvcDecodePkg::invalid})
			return 15'd0;
		case (w[1:0])
			2'b00: begin
				if (f == 3'd0) return {cl, 5'd2, 5'd0};
				if (c == rvcDecodePkg::load) return {cl, ch, 5'd0};
				return {5'd0, ch, cl};
			end
			2'b01: begin
				if (f == 3'd2 || (f == 3'd3 && hi != 5'd2)) return {hi, 5'd0, 5'd0};
				if (f <= 3'd3) return {hi, hi, 5'd0};
				if (f == 3'd4) return {ch, ch, (c == rvcDecodePkg::aluReg) ? cl : 5'd0};
				if (f == 3'd5) return 15'd0;
				return {5'd0, ch, 5'd0};
			end
			default: begin
				if (f == 3'd0) return {hi, hi, 5'd0};
				if (c == rvcDecodePkg::load) return {hi, 5'd2, 5'd0};
				if (c == rvcDecodePkg::store) return {5'd0, 5'd2, lo};
				if (c == rvcDecodePkg::aluReg) return {hi, hi, lo};
				return {4'd0, w[12], hi, 5'd0};
			end
		endcase
	endfunction

	function automatic logic [63:0] immOf(input logic [15:0] w);
		logic [2:0] f;
		logic [63:0] s6;
		logic [63:0] u6;
		f = w[15:13];
		s6 = {{58{w[12]}}, w[12], w[6:2]};
		u6 = {58'd0, w[12], w[6:2]};
		if (classOf(w) inside {rvcDecodePkg::nop, rvcDecodePkg::brk, rvcDecodePkg::invalid})
			return 64'd0;
		case ({w[1:0], f})
			5'b00000: return {54'd0, w[10:7], w[12:11], w[5], w[6], 2'b00};
			5'b00010, 5'b00110: return {57'd0, w[5], w[12:10], w[6], 2'b00};
			5'b00011, 5'b00111: return {56'd0, w[6:5], w[12:10], 3'b000};
			5'b01000, 5'b01001, 5'b01010: return s6;
			5'b01011: begin
				if (w[11:7] == 5'd2)
					return {{54{w[12]}}, w[12], w[4:3], w[5], w[2], w[6], 4'd0};
				return s6 << 12;
			end
			5'b01100: begin
				if (w[11:10] == 2'b10) return s6;
				if (w[11:10] == 2'b11) return 64'd0;
				return u6;
			end
			5'b01101: return {{52{w[12]}}, w[12], w[8], w[10:9], w[6], w[7], w[2], w[11],
				w[5:3], 1'b0};
			5'b01110, 5'b01111: return {{55{w[12]}}, w[12], w[6:5], w[2], w[11:10], w[4:3],
				1'b0};
			5'b10000: return u6;
			5'b10010: return {56'd0, w[3:2], w[12], w[6:4], 2'b00};
			5'b10011: return {55'd0, w[4:2], w[12], w[6:5], 3'b000};
			5'b10110: return {56'd0, w[8:7], w[12:9], 2'b00};
			5'b10111: return {55'd0, w[9:7], w[12:10], 3'b000};
			default: return 64'd0;
		endcase
	endfunction

	// two-deep shadow of the input so word2 lines up with outValid
	always_ff @(posedge clock) begin
		word1 <= inInstr;
		word2 <= word1;
		acc1 <= reset ? 1'b0 : (inValid && inReady);
		acc2 <= reset ? 1'b0 : acc1;
		if (reset) begin
			outstanding <= 0;
		end else begin
			outstanding <= outstanding + int'(inValid && inReady) - int'(creditReturn);
		end
	end

	assign expClass = classOf(word2);
	assign expAlu = aluOf(word2);
	assign expRegs = regsOf(word2);
	assign expImm = immOf(word2);

	latencyCheck: assert property (@(posedge clock) disable iff (reset) outValid == acc2)
		else begin
			noteFailure("latency", 64'($sampled(acc2)), 64'($sampled(outValid)));
			$error("outValid does not follow acceptance by two cycles");
		end

	readyCheck: assert property (@(posedge clock) disable iff (reset)
		inReady == (outstanding < numCredits))
		else begin
			noteFailure("inReady", 64'($sampled(outstanding) < numCredits),
				64'($sampled(inReady)));
			$error("inReady disagrees with the credits held");
		end

	classCheck: assert property (@(posedge clock) disable iff (reset)
		outValid |-> outOpClass == expClass)
		else begin
			noteFailure("opClass", 64'($sampled(expClass)), 64'($sampled(outOpClass)));
			$error("wrong operation class");
		end

	aluCheck: assert property (@(posedge clock) disable iff (reset)
		(outValid && expClass inside {rvcDecodePkg::aluReg, rvcDecodePkg::aluImm})
		|-> outAluFunc == expAlu)
		else begin
			noteFailure("aluFunc", 64'($sampled(expAlu)), 64'($sampled(outAluFunc)));
			$error("wrong ALU function");
		end

	regCheck: assert property (@(posedge clock) disable iff (reset)
		outValid |-> {outRd, outRs1, outRs2} == expRegs)
		else begin
			noteFailure("registers", 64'($sampled(expRegs)),
				64'($sampled({outRd, outRs1, outRs2})));
			$error("wrong register numbers");
		end

	immCheck: assert property (@(posedge clock) disable iff (reset)
		outValid |-> outImm == immWidth'(expImm))
		else begin
			noteFailure("immediate", 64'(immWidth'($sampled(expImm))), 64'($sampled(outImm)));
			$error("wrong immediate");
		end

	sizeCheck: assert property (@(posedge clock) disable iff (reset)
		(outValid && outOpClass inside {rvcDecodePkg::load, rvcDecodePkg::store})
		|-> outMemSize == (word2[13] ? rvcDecodePkg::double : rvcDecodePkg::word))
		else begin
			noteFailure("memSize", 64'($sampled(word2[13])), 64'($sampled(outMemSize)));
			$error("wrong access size");
		end

endmodule

bind rvcDecoder rvcDecoderAssertions #(
	.immWidth(immWidth),
	.numCredits(numCredits)
) checks (
	.clock(clock),
	.reset(reset),
	.inValid(inValid),
	.inInstr(inInstr),
	.inReady(inReady),
	.creditReturn(creditReturn),
	.outValid(outValid),
	.outOpClass(outOpClass),
	.outAluFunc(outAluFunc),
	.outMemSize(outMemSize),
	.outRd(outRd),
	.outRs1(outRs1),
	.outRs2(outRs2),
	.outImm(outImm)
);

//--- dv/tbClockGen.sv
// --------------------------------------------------
// 10 ns clock, reset held high for the first 4 edges
// --------------------------------------------------
`timescale 1ns/1ps

module tbClockGen (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

//--- hw/rvcClassifyStage.sv
// --------------------------------------------------
// stage 1: opcode match into class, function, layout and imm kind
// LUI and ADDI16SP with a zero immediate are not flagged as reserved
// --------------------------------------------------
`timescale 1ns/1ps

module rvcClassifyStage (
	input logic clock,
	input logic reset,
	input logic accept,
	input logic [rvcDecodePkg::instrWidth-1:0] inInstr,
	rvcStageIf.producer stage
);

	rvcDecodePkg::opClassT opClass;
	rvcDecodePkg::aluFuncT aluFunc;
	rvcDecodePkg::memSizeT memSize;
	rvcDecodePkg::formatT format;
	rvcDecodePkg::immKindT immKind;
	logic [2:0] funct3;
	logic rdZero;
	logic rs2Zero;

	assign funct3 = inInstr[15:13];
	assign rdZero = (inInstr[11:7] == 5'd0);
	assign rs2Zero = (inInstr[6:2] == 5'd0);

	always_comb begin
		opClass = rvcDecodePkg::invalid;
		aluFunc = rvcDecodePkg::add;
		memSize = rvcDecodePkg::word;
		format = rvcDecodePkg::none;
		immKind = rvcDecodePkg::noImm;

		case (inInstr[1:0])
			2'b00: begin
				case (funct3)
					3'b000: begin
						if (inInstr == '0) begin
							opClass = rvcDecodePkg::brk;
						end else begin
							opClass = rvcDecodePkg::aluImm;
							format = rvcDecodePkg::spAddImm;
							immKind = rvcDecodePkg::addi4spn;
						end
					end
					3'b010, 3'b011, 3'b110, 3'b111: begin
						opClass = funct3[2] ? rvcDecodePkg::store : rvcDecodePkg::load;
						memSize = funct3[0] ? rvcDecodePkg::double : rvcDecodePkg::word;
						format = rvcDecodePkg::loadStoreComp;
						immKind = funct3[0] ? rvcDecodePkg::offsetDouble
							: rvcDecodePkg::offsetWord;
					end
					// FLD, FSD and the reserved code stay invalid
					default: begin
					end
				endcase
			end
			2'b01: begin
				case (funct3)
					3'b000, 3'b001, 3'b010: begin
						opClass = rvcDecodePkg::aluImm;
						aluFunc = (funct3 == 3'b001) ? rvcDecodePkg::addWord
							: rvcDecodePkg::add;
						format = rvcDecodePkg::immFull;
						immKind = rvcDecodePkg::imm6Signed;
						if (funct3 == 3'b000 && rdZero) begin
							opClass = rvcDecodePkg::nop;
							format = rvcDecodePkg::none;
							immKind = rvcDecodePkg::noImm;
						end
					end
					3'b011: begin
						opClass = rvcDecodePkg::aluImm;
						format = rvcDecodePkg::immFull;
						// rd of x2 turns LUI into ADDI16SP
						immKind = (inInstr[11:7] == 5'd2) ? rvcDecodePkg::addi16sp
							: rvcDecodePkg::lui;
					end
					3'b100: begin
						case (inInstr[11:10])
							2'b00, 2'b01, 2'b10: begin
								opClass = rvcDecodePkg::aluImm;
								format = rvcDecodePkg::immComp;
								case (inInstr[11:10])
									2'b00: aluFunc = rvcDecodePkg::shiftRightLogic;
									2'b01: aluFunc = rvcDecodePkg::shiftRightArith;
									default: aluFunc = rvcDecodePkg::andOp;
								endcase
								immKind = (inInstr[11:10] == 2'b10) ? rvcDecodePkg::imm6Signed
									: rvcDecodePkg::imm6Zero;
							end
							default: begin
								opClass = rvcDecodePkg::aluReg;
								format = rvcDecodePkg::regRegComp;
								case ({inInstr[12], inInstr[6:5]})
									3'b000: aluFunc = rvcDecodePkg::sub;
									3'b001: aluFunc = rvcDecodePkg::xorOp;
									3'b010: aluFunc = rvcDecodePkg::orOp;
									3'b011: aluFunc = rvcDecodePkg::andOp;
									3'b100: aluFunc = rvcDecodePkg::subWord;
									3'b101: aluFunc = rvcDecodePkg::addWord;
									default: begin
										opClass = rvcDecodePkg::invalid;
										format = rvcDecodePkg::none;
									end
								endcase
							end
						endcase
					end
					3'b101: begin
						opClass = rvcDecodePkg::jump;
						format = rvcDecodePkg::pcRel;
						immKind = rvcDecodePkg::jumpOffset;
					end
					default: begin
						opClass = funct3[0] ? rvcDecodePkg::branchNe : rvcDecodePkg::branchEq;
						format = rvcDecodePkg::branchComp;
						immKind = rvcDecodePkg::branchOffset;
					end
				endcase
			end
			2'b10: begin
				case (funct3)
					3'b000: begin
						opClass = rvcDecodePkg::aluImm;
						aluFunc = rvcDecodePkg::shiftLeft;
						format = rvcDecodePkg::immFull;
						immKind = rvcDecodePkg::imm6Zero;
					end
					3'b010, 3'b011: begin
						opClass = rvcDecodePkg::load;
						memSize = funct3[0] ? rvcDecodePkg::double : rvcDecodePkg::word;
						format = rvcDecodePkg::stackLoad;
						immKind = funct3[0] ? rvcDecodePkg::stackLoadDouble
							: rvcDecodePkg::stackLoadWord;
					end
					3'b100: begin
						if (rs2Zero && rdZero) begin
							// reserved JR x0 and EBREAK both trap
							opClass = rvcDecodePkg::brk;
						end else if (rs2Zero) begin
							opClass = inInstr[12] ? rvcDecodePkg::jumpLink : rvcDecodePkg::jump;
							format = rvcDecodePkg::regJump;
						end else begin
							opClass = rvcDecodePkg::aluReg;
							aluFunc = inInstr[12] ? rvcDecodePkg::add : rvcDecodePkg::move;
							format = rvcDecodePkg::regRegFull;
						end
					end
					3'b110, 3'b111: begin
						opClass = rvcDecodePkg::store;
						memSize = funct3[0] ? rvcDecodePkg::double : rvcDecodePkg::word;
						format = rvcDecodePkg::stackStore;
						immKind = funct3[0] ? rvcDecodePkg::stackStoreDouble
							: rvcDecodePkg::stackStoreWord;
					end
					// FLDSP and FSDSP
					default: begin
					end
				endcase
			end
			// 32-bit encodings are handled elsewhere
			default: begin
				opClass = rvcDecodePkg::nop;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			stage.valid <= 1'b0;
		end else begin
			stage.valid <= accept;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			stage.instr <= inInstr;
			stage.opClass <= opClass;
			stage.aluFunc <= aluFunc;
			stage.memSize <= memSize;
			stage.format <= format;
			stage.immKind <= immKind;
		end
	end

endmodule

//--- hw/rvcCreditCounter.sv
// --------------------------------------------------
// credits mirror free slots in the downstream buffer
// downstream must not return more than it has received
// --------------------------------------------------
`timescale 1ns/1ps

module rvcCreditCounter #(
	parameter int numCredits = 4
) (
	input logic clock,
	input logic reset,
	input logic inValid,
	input logic creditReturn,
	output logic inReady,
	output logic accept
);

	localparam int countWidth = $clog2(numCredits + 1);

	logic [countWidth-1:0] creditCount;

	assign inReady = (creditCount != '0);

	// the only place the acceptance condition is formed
	assign accept = inValid && inReady;

	always_ff @(posedge clock) begin
		if (reset) begin
			creditCount <= countWidth'(numCredits);
		end else begin
			// spend and return in the same cycle cancel out
			if (accept && !creditReturn) begin
				creditCount <= creditCount - 1'b1;
			end else if (creditReturn && !accept) begin
				// saturate so a stray return cannot wrap the count
				if (creditCount != countWidth'(numCredits)) begin
					creditCount <= creditCount + 1'b1;
				end
			end
		end
	end

endmodule

//--- hw/rvcDecodePkg.sv
// --------------------------------------------------
// shared types and constants for the RVC decoder
// targets RV64 integer only; float register file is not decoded
// --------------------------------------------------
package rvcDecodePkg;

	// widths
	localparam int instrWidth = 16;
	localparam int regIndexWidth = 5;

	// fixed register numbers in plain x0..x31 numbering
	localparam int zeroReg = 0;
	localparam int linkReg = 1;
	localparam int stackReg = 2;

	// a 3-bit field x selects register compressedRegBase + x
	localparam int compressedRegBase = 8;

	typedef enum logic [3:0] {
		aluReg,
		aluImm,
		load,
		store,
		jump,
		jumpLink,
		branchEq,
		branchNe,
		brk,
		nop,
		invalid
	} opClassT;

	typedef enum logic [3:0] {
		add,
		addWord,
		sub,
		subWord,
		andOp,
		orOp,
		xorOp,
		shiftLeft,
		shiftRightLogic,
		shiftRightArith,
		move
	} aluFuncT;

	// word is 4 bytes, double is 8 bytes
	typedef enum logic {
		word,
		double
	} memSizeT;

	// register layout, picks how stage 2 forms rd, rs1 and rs2
	typedef enum logic [3:0] {
		regRegFull,
		regRegComp,
		immFull,
		immComp,
		loadStoreComp,
		stackLoad,
		stackStore,
		spAddImm,
		pcRel,
		branchComp,
		regJump,
		none
	} formatT;

	// immediate scramble selector
	typedef enum logic [3:0] {
		imm6Signed,
		imm6Zero,
		lui,
		addi16sp,
		addi4spn,
		offsetWord,
		offsetDouble,
		stackLoadWord,
		stackLoadDouble,
		stackStoreWord,
		stackStoreDouble,
		jumpOffset,
		branchOffset,
		noImm
	} immKindT;

endpackage

//--- hw/rvcDecoder.sv
// --------------------------------------------------
// RVC decoder top, two registered stages, credit flow control
// outValid follows an acceptance by exactly two cycles
// --------------------------------------------------
`timescale 1ns/1ps

module rvcDecoder #(
	parameter int immWidth = 32,
	parameter int numCredits = 4
) (
	input logic clock,
	input logic reset,
	input logic inValid,
	input logic [rvcDecodePkg::instrWidth-1:0] inInstr,
	output logic inReady,
	output logic outValid,
	output rvcDecodePkg::opClassT outOpClass,
	output rvcDecodePkg::aluFuncT outAluFunc,
	output rvcDecodePkg::memSizeT outMemSize,
	output logic [rvcDecodePkg::regIndexWidth-1:0] outRd,
	output logic [rvcDecodePkg::regIndexWidth-1:0] outRs1,
	output logic [rvcDecodePkg::regIndexWidth-1:0] outRs2,
	output logic [immWidth-1:0] outImm,
	input logic creditReturn
);

	logic accept;

	rvcStageIf stageLink ();

	rvcCreditCounter #(
		.numCredits(numCredits)
	) creditCounter (
		.clock(clock),
		.reset(reset),
		.inValid(inValid),
		.creditReturn(creditReturn),
		.inReady(inReady),
		.accept(accept)
	);

	rvcClassifyStage classifyStage (
		.clock(clock),
		.reset(reset),
		.accept(accept),
		.inInstr(inInstr),
		.stage(stageLink.producer)
	);

	rvcOperandStage #(
		.immWidth(immWidth)
	) operandStage (
		.clock(clock),
		.reset(reset),
		.stage(stageLink.consumer),
		.outValid(outValid),
		.outOpClass(outOpClass),
		.outAluFunc(outAluFunc),
		.outMemSize(outMemSize),
		.outRd(outRd),
		.outRs1(outRs1),
		.outRs2(outRs2),
		.outImm(outImm)
	);

endmodule

//--- hw/rvcOperandStage.sv
// --------------------------------------------------
// stage 2: register numbers and extended immediate
// immWidth must be at least 21; registers unused by a format read as x0
// --------------------------------------------------
`timescale 1ns/1ps

module rvcOperandStage #(
	parameter int immWidth = 32
) (
	input logic clock,
	input logic reset,
	rvcStageIf.consumer stage,
	output logic outValid,
	output rvcDecodePkg::opClassT outOpClass,
	output rvcDecodePkg::aluFuncT outAluFunc,
	output rvcDecodePkg::memSizeT outMemSize,
	output logic [rvcDecodePkg::regIndexWidth-1:0] outRd,
	output logic [rvcDecodePkg::regIndexWidth-1:0] outRs1,
	output logic [rvcDecodePkg::regIndexWidth-1:0] outRs2,
	output logic [immWidth-1:0] outImm
);

	localparam int rawWidth = 20;
	localparam int rw = rvcDecodePkg::regIndexWidth;
	localparam logic [rw-1:0] regZero = rw'(rvcDecodePkg::zeroReg);
	localparam logic [rw-1:0] regLink = rw'(rvcDecodePkg::linkReg);
	localparam logic [rw-1:0] regStack = rw'(rvcDecodePkg::stackReg);

	logic [rvcDecodePkg::instrWidth-1:0] ins;
	logic [rw-1:0] fullHi;
	logic [rw-1:0] fullLo;
	logic [rw-1:0] compHi;
	logic [rw-1:0] compLo;
	logic [rw-1:0] rd;
	logic [rw-1:0] rs1;
	logic [rw-1:0] rs2;
	logic [rawWidth-1:0] immRaw;
	logic rs1Forced;

	assign ins = stage.instr;
	assign fullHi = ins[11:7];
	assign fullLo = ins[6:2];
	assign compHi = rw'(rvcDecodePkg::compressedRegBase) + rw'(ins[9:7]);
	assign compLo = rw'(rvcDecodePkg::compressedRegBase) + rw'(ins[4:2]);

	// LI and LUI read x0 instead of rd
	assign rs1Forced = (stage.immKind == rvcDecodePkg::lui)
		|| (ins[1:0] == 2'b01 && ins[15:13] == 3'b010);

	always_comb begin
		rd = regZero;
		rs1 = regZero;
		rs2 = regZero;
		case (stage.format)
			rvcDecodePkg::regRegFull: begin
				rd = fullHi;
				rs1 = fullHi;
				rs2 = fullLo;
			end
			rvcDecodePkg::regRegComp: begin
				rd = compHi;
				rs1 = compHi;
				rs2 = compLo;
			end
			rvcDecodePkg::immFull: begin
				rd = fullHi;
				rs1 = rs1Forced ? regZero : fullHi;
			end
			rvcDecodePkg::immComp: begin
				rd = compHi;
				rs1 = compHi;
			end
			rvcDecodePkg::loadStoreComp: begin
				rs1 = compHi;
				if (stage.opClass == rvcDecodePkg::load) begin
					rd = compLo;
				end else begin
					rs2 = compLo;
				end
			end
			rvcDecodePkg::stackLoad: begin
				rs1 = regStack;
				rd = fullHi;
			end
			rvcDecodePkg::stackStore: begin
				rs1 = regStack;
				rs2 = fullLo;
			end
			rvcDecodePkg::spAddImm: begin
				rs1 = regStack;
				rd = compLo;
			end
			rvcDecodePkg::branchComp: rs1 = compHi;
			rvcDecodePkg::regJump: begin
				rs1 = fullHi;
				rd = (stage.opClass == rvcDecodePkg::jumpLink) ? regLink : regZero;
			end
			// pcRel and none keep x0 everywhere
			default: begin
			end
		endcase
	end

	// every kind lands in 20 bits, unsigned kinds have a clear top bit
	always_comb begin
		case (stage.immKind)
			rvcDecodePkg::imm6Signed: immRaw = {{14{ins[12]}}, ins[12], ins[6:2]};
			rvcDecodePkg::imm6Zero: immRaw = {14'd0, ins[12], ins[6:2]};
			rvcDecodePkg::lui: immRaw = {{2{ins[12]}}, ins[12], ins[6:2], 12'd0};
			rvcDecodePkg::addi16sp: immRaw = {{10{ins[12]}}, ins[12], ins[4:3], ins[5],
				ins[2], ins[6], 4'd0};
			rvcDecodePkg::addi4spn: immRaw = {10'd0, ins[10:7], ins[12:11], ins[5], ins[6],
				2'd0};
			rvcDecodePkg::offsetWord: immRaw = {13'd0, ins[5], ins[12:10], ins[6], 2'd0};
			rvcDecodePkg::offsetDouble: immRaw = {12'd0, ins[6:5], ins[12:10], 3'd0};
			rvcDecodePkg::stackLoadWord: immRaw = {12'd0, ins[3:2], ins[12], ins[6:4], 2'd0};
			rvcDecodePkg::stackLoadDouble: immRaw = {11'd0, ins[4:2], ins[12], ins[6:5], 3'd0};
			rvcDecodePkg::stackStoreWord: immRaw = {12'd0, ins[8:7], ins[12:9], 2'd0};
			rvcDecodePkg::stackStoreDouble: immRaw = {11'd0, ins[9:7], ins[12:10], 3'd0};
			rvcDecodePkg::jumpOffset: immRaw = {{8{ins[12]}}, ins[12], ins[8], ins[10:9],
				ins[6], ins[7], ins[2], ins[11], ins[5:3], 1'b0};
			rvcDecodePkg::branchOffset: immRaw = {{11{ins[12]}}, ins[12], ins[6:5], ins[2],
				ins[11:10], ins[4:3], 1'b0};
			default: immRaw = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			outValid <= 1'b0;
		end else begin
			outValid <= stage.valid;
		end
	end

	always_ff @(posedge clock) begin
		if (stage.valid) begin
			outOpClass <= stage.opClass;
			outAluFunc <= stage.aluFunc;
			outMemSize <= stage.memSize;
			outRd <= rd;
			outRs1 <= rs1;
			outRs2 <= rs2;
			outImm <= {{(immWidth - rawWidth){immRaw[rawWidth-1]}}, immRaw};
		end
	end

endmodule

//--- hw/rvcStageIf.sv
// --------------------------------------------------
// link from the classify stage to the operand stage
// payload is only meaningful while valid is high
// --------------------------------------------------
`timescale 1ns/1ps

interface rvcStageIf;

	logic valid;
	logic [rvcDecodePkg::instrWidth-1:0] instr;
	rvcDecodePkg::opClassT opClass;
	rvcDecodePkg::aluFuncT aluFunc;
	rvcDecodePkg::memSizeT memSize;
	rvcDecodePkg::formatT format;
	rvcDecodePkg::immKindT immKind;

	modport producer (
		output valid, instr, opClass, aluFunc, memSize, format, immKind
	);

	modport consumer (
		input valid, instr, opClass, aluFunc, memSize, format, immKind
	);

endinterface
